//--- Bender.yml
package:
  name: exwb

sources:
  - files:
      - exwb_pkg.sv
      - issue_queue.sv
      - regfile.sv
      - operand_forward.sv
      - exec_lane.sv
      - mul_split.sv
      - mem_wb_stage.sv
      - exwb_top.sv
  - target: test
    files:
      - tb_exwb.sv

//--- exec_lane.sv
`timescale 1ns/1ps
`default_nettype none

module exec_lane (
    input  exwb_pkg::slot_t             slot,
    input  logic [exwb_pkg::XLEN-1:0]   op1,
    input  logic [exwb_pkg::XLEN-1:0]   op2,
    output logic [exwb_pkg::XLEN-1:0]   result
);
    import exwb_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [4:0]      shamt;

    assign src_a = (slot.src1 == SRC_PC)  ? slot.pc  : op1;
    assign src_b = (slot.src2 == SRC_IMM) ? slot.imm : op2;
    assign shamt = src_b[4:0];

    always_comb begin
        unique case (slot.alu_op)
            ADD:     result = src_a + src_b;
            SUB:     result = src_a - src_b;
            AND:     result = src_a & src_b;
            OR:      result = src_a | src_b;
            XOR:     result = src_a ^ src_b;
            SLL:     result = src_a << shamt;
            SRL:     result = src_a >> shamt;
            SRA:     result = $signed(src_a) >>> shamt;
            SLT:     result = XLEN'($signed(src_a) < $signed(src_b));
            SLTU:    result = XLEN'(src_a < src_b);
            default: result = '0;                                   // Multiplies come from mul_split
        endcase
    end

endmodule

`default_nettype wire

//--- exwb_pkg.sv
`default_nettype none

package exwb_pkg;

    localparam int XLEN          = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int NUM_REGS      = 2 ** REG_ADDR_W;
    localparam int NUM_SRC       = 4;                               // Two sources per lane

    localparam int ISSUE_CREDITS = 4;                               // Queue depth
    localparam int ISSUE_PTR_W   = $clog2(ISSUE_CREDITS);
    localparam int ISSUE_CNT_W   = $clog2(ISSUE_CREDITS + 1);

    localparam int WB_CREDITS    = 2;                               // Initial output credits
    localparam int WB_CNT_W      = $clog2(WB_CREDITS + 1);

    // Multiply codes are only legal in lane B
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        MUL,                                                        // Low word
        MULH,                                                       // High word, signed
        MULHU                                                       // High word, unsigned
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,                                                    // Second operand only
        SRC_PC                                                      // First operand only
    } src_sel_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] raddr1;
        logic [REG_ADDR_W-1:0] raddr2;
        src_sel_e              src1;
        src_sel_e              src2;
        alu_op_e               alu_op;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] waddr;
    } slot_t;

    typedef struct packed {
        slot_t a;
        slot_t b;
    } issue_pair_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       pc;
    } wb_write_t;

    typedef struct packed {
        wb_write_t a;
        wb_write_t b;
    } wb_pair_t;

    typedef struct packed {
        logic [2*XLEN-1:0] pp_lo;                                   // x times low half of y
        logic [2*XLEN-1:0] pp_hi;                                   // x times high half of y
        alu_op_e           op;
    } mul_part_t;

endpackage

`default_nettype wire

//--- exwb_top.sv
`timescale 1ns/1ps
`default_nettype none

module exwb_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  exwb_pkg::issue_pair_t issue_pair,
    output logic                  credit_return,
    output logic                  wb_valid,
    output exwb_pkg::wb_pair_t    wb_pair,
    input  logic                  wb_credit
);
    import exwb_pkg::*;

    logic                                 advance;
    logic                                 head_valid;
    issue_pair_t                          head;
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0]   raddr;
    logic [NUM_SRC-1:0][XLEN-1:0]         rf_data;
    logic [NUM_SRC-1:0][XLEN-1:0]         operands;             // a1, a2, b1, b2
    logic [XLEN-1:0]                      result_a;
    logic [XLEN-1:0]                      result_b;
    logic [XLEN-1:0]                      product;
    logic                                 mem_valid;
    wb_pair_t                             mem_pair;
    logic                                 wb_full;

    assign raddr = {head.b.raddr2, head.b.raddr1, head.a.raddr2, head.a.raddr1};

    issue_queue queue_i (
        .clk(clk), .reset(reset),
        .issue_valid(issue_valid), .issue_pair(issue_pair),
        .advance(advance), .head_valid(head_valid), .head(head),
        .credit_return(credit_return)
    );

    regfile regfile_i (
        .clk(clk), .reset(reset),
        .raddr(raddr), .rdata(rf_data),
        .wr(wb_pair), .wr_en(wb_valid)                              // Writes land as pairs leave
    );

    operand_forward forward_i (
        .rf_data(rf_data), .raddr(raddr),
        .mem_pair(mem_pair), .mem_valid(mem_valid),
        .wb_pair(wb_pair), .wb_full(wb_full),
        .operands(operands)
    );

    exec_lane lane_a_i (.slot(head.a), .op1(operands[0]), .op2(operands[1]), .result(result_a));
    exec_lane lane_b_i (.slot(head.b), .op1(operands[2]), .op2(operands[3]), .result(result_b));

    // Multiplier takes lane B register operands
    mul_split mul_i (
        .clk(clk), .reset(reset), .advance(advance),
        .x(operands[2]), .y(operands[3]), .op(head.b.alu_op),
        .product(product)
    );

    mem_wb_stage mem_wb_i (
        .clk(clk), .reset(reset),
        .ex_valid(head_valid), .ex_pair(head),
        .result_a(result_a), .result_b(result_b), .product(product),
        .wb_credit(wb_credit), .advance(advance),
        .mem_valid(mem_valid), .mem_pair(mem_pair),
        .wb_full(wb_full), .wb_pair(wb_pair), .wb_valid(wb_valid)
    );

endmodule

`default_nettype wire

//--- issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  exwb_pkg::issue_pair_t issue_pair,
    input  logic                  advance,
    output logic                  head_valid,
    output exwb_pkg::issue_pair_t head,
    output logic                  credit_return
);
    import exwb_pkg::*;

    issue_pair_t            fifo_mem [ISSUE_CREDITS];
    logic [ISSUE_PTR_W-1:0] wr_ptr;
    logic [ISSUE_PTR_W-1:0] rd_ptr;
    logic [ISSUE_CNT_W-1:0] count;
    logic                   pop;

    assign head_valid = (count != '0);
    assign head       = fifo_mem[rd_ptr];                          // Show-ahead head
    assign pop        = advance && head_valid;

    // Upstream credits keep the push from ever hitting a full queue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            fifo_mem[wr_ptr] <= issue_pair;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (issue_valid) begin
                if (wr_ptr == ISSUE_PTR_W'(ISSUE_CREDITS - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == ISSUE_PTR_W'(ISSUE_CREDITS - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            count         <= count + ISSUE_CNT_W'(issue_valid) - ISSUE_CNT_W'(pop);
            credit_return <= pop;                                   // One pulse per entry left
        end
    end

endmodule

`default_nettype wire

//--- mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ex_valid,
    input  exwb_pkg::issue_pair_t       ex_pair,
    input  logic [exwb_pkg::XLEN-1:0]   result_a,
    input  logic [exwb_pkg::XLEN-1:0]   result_b,
    input  logic [exwb_pkg::XLEN-1:0]   product,
    input  logic                        wb_credit,
    output logic                        advance,
    output logic                        mem_valid,
    output exwb_pkg::wb_pair_t          mem_pair,
    output logic                        wb_full,
    output exwb_pkg::wb_pair_t          wb_pair,
    output logic                        wb_valid
);
    import exwb_pkg::*;

    issue_pair_t         mem_slots;
    logic [XLEN-1:0]     mem_res_a;
    logic [XLEN-1:0]     mem_res_b;
    logic                b_is_mul;
    logic [WB_CNT_W-1:0] credits;

    assign wb_valid = wb_full && (credits != '0);
    assign advance  = !wb_full || wb_valid;                         // Whole pipe moves together

    // MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (advance) begin
            mem_valid <= ex_valid;                                  // Bubble when queue is empty
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_slots <= ex_pair;
            mem_res_a <= result_a;
            mem_res_b <= result_b;
        end
    end

    // Write-back mux
    assign b_is_mul = mem_slots.b.alu_op inside {MUL, MULH, MULHU};

    always_comb begin
        mem_pair.a.we    = mem_slots.a.rf_we;
        mem_pair.a.waddr = mem_slots.a.waddr;
        mem_pair.a.wdata = mem_res_a;
        mem_pair.a.pc    = mem_slots.a.pc;
        mem_pair.b.we    = mem_slots.b.rf_we;
        mem_pair.b.waddr = mem_slots.b.waddr;
        mem_pair.b.wdata = b_is_mul ? product : mem_res_b;
        mem_pair.b.pc    = mem_slots.b.pc;
    end

    // WB register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_full <= 1'b0;
        end else if (advance) begin
            wb_full <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_pair <= mem_pair;
        end
    end

    // Output credits
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= WB_CNT_W'(WB_CREDITS);
        end else begin
            credits <= credits + WB_CNT_W'(wb_credit) - WB_CNT_W'(wb_valid);
        end
    end

endmodule

`default_nettype wire

//--- mul_split.sv
`timescale 1ns/1ps
`default_nettype none

module mul_split (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        advance,
    input  logic [exwb_pkg::XLEN-1:0]   x,
    input  logic [exwb_pkg::XLEN-1:0]   y,
    input  exwb_pkg::alu_op_e           op,
    output logic [exwb_pkg::XLEN-1:0]   product
);
    import exwb_pkg::*;

    logic signed [XLEN:0]        x_ext;                             // 33 bits
    logic signed [XLEN:0]        y_ext;
    logic signed [XLEN/2:0]      y_lo;                              // Low half, zero extended
    logic signed [XLEN/2:0]      y_hi;                              // High half with sign bit
    logic                        sext;
    mul_part_t                   part_d;
    mul_part_t                   part_q;
    logic        [2*XLEN-1:0]    sum;

    // EX half
    assign sext   = (op != MULHU);
    assign x_ext  = {sext & x[XLEN-1], x};
    assign y_ext  = {sext & y[XLEN-1], y};
    assign y_lo   = {1'b0, y_ext[XLEN/2-1:0]};
    assign y_hi   = y_ext[XLEN:XLEN/2];

    assign part_d.pp_lo = x_ext * y_lo;
    assign part_d.pp_hi = x_ext * y_hi;
    assign part_d.op    = op;

    always_ff @(posedge clk) begin
        if (reset) begin
            part_q.op <= ADD;
        end else if (advance) begin
            part_q <= part_d;
        end
    end

    // MEM half
    assign sum     = part_q.pp_lo + (part_q.pp_hi << (XLEN / 2));
    assign product = (part_q.op == MUL) ? sum[XLEN-1:0] : sum[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

//--- operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  logic [exwb_pkg::NUM_SRC-1:0][exwb_pkg::XLEN-1:0]       rf_data,
    input  logic [exwb_pkg::NUM_SRC-1:0][exwb_pkg::REG_ADDR_W-1:0] raddr,
    input  exwb_pkg::wb_pair_t                                   mem_pair,
    input  logic                                                 mem_valid,
    input  exwb_pkg::wb_pair_t                                   wb_pair,
    input  logic                                                 wb_full,
    output logic [exwb_pkg::NUM_SRC-1:0][exwb_pkg::XLEN-1:0]       operands
);
    import exwb_pkg::*;

    function automatic logic hits(
        input logic                  stage_valid,
        input wb_write_t             w,
        input logic [REG_ADDR_W-1:0] addr
    );
        return stage_valid && w.we && (w.waddr == addr);
    endfunction

    // Newest producer first, the register file last
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            if (raddr[i] == '0) begin
                operands[i] = '0;                                   // Zero is never forwarded
            end else if (hits(mem_valid, mem_pair.b, raddr[i])) begin
                operands[i] = mem_pair.b.wdata;
            end else if (hits(mem_valid, mem_pair.a, raddr[i])) begin
                operands[i] = mem_pair.a.wdata;
            end else if (hits(wb_full, wb_pair.b, raddr[i])) begin
                operands[i] = wb_pair.b.wdata;
            end else if (hits(wb_full, wb_pair.a, raddr[i])) begin
                operands[i] = wb_pair.a.wdata;
            end else begin
                operands[i] = rf_data[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic [exwb_pkg::NUM_SRC-1:0][exwb_pkg::REG_ADDR_W-1:0] raddr,
    output logic [exwb_pkg::NUM_SRC-1:0][exwb_pkg::XLEN-1:0]       rdata,
    input  exwb_pkg::wb_pair_t                                   wr,
    input  logic                                                 wr_en
);
    import exwb_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // Asynchronous read ports
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            rdata[i] = regs[raddr[i]];
        end
    end

    // Lane B is written last so it wins on equal waddr
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            if (wr.a.we && wr.a.waddr != '0) begin
                regs[wr.a.waddr] <= wr.a.wdata;
            end
            if (wr.b.we && wr.b.waddr != '0) begin
                regs[wr.b.waddr] <= wr.b.wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb.f
exwb_pkg.sv
issue_queue.sv
regfile.sv
operand_forward.sv
exec_lane.sv
mul_split.sv
mem_wb_stage.sv
exwb_top.sv
tb_exwb.sv

//--- tb_exwb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exwb;
    import exwb_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int N_SPACED     = 40;
    localparam int N_DEP        = 60;
    localparam int N_MUL        = 40;
    localparam int N_AFTER      = 20;
    localparam int HOLD_CYCLES  = 30;                               // Longest credit gap
    localparam int PIPE_DEPTH   = ISSUE_CREDITS + 3;
    localparam int NUM_PAIRS    = 2 + N_SPACED + N_DEP + N_MUL + HOLD_CYCLES + N_AFTER;
    localparam int LIMIT_CYCLES = NUM_PAIRS * (PIPE_DEPTH + HOLD_CYCLES);

    logic        clk;
    logic        reset;
    logic        issue_valid;
    issue_pair_t issue_pair;
    logic        credit_return;
    logic        wb_valid;
    wb_pair_t    wb_pair;
    logic        wb_credit;

    logic [XLEN-1:0] shadow [NUM_REGS];                             // Reference register file
    wb_pair_t        exp_q [$];
    logic [31:0]     lcg_state;
    string           test_name;
    logic            hold;
    int issue_credits = ISSUE_CREDITS;
    int out_credits   = WB_CREDITS;
    int accepted      = 0;
    int returns       = 0;
    int delivered     = 0;
    int pending       = 0;                                          // Credits owed to the DUT

    exwb_top dut_i (
        .clk(clk), .reset(reset),
        .issue_valid(issue_valid), .issue_pair(issue_pair),
        .credit_return(credit_return),
        .wb_valid(wb_valid), .wb_pair(wb_pair), .wb_credit(wb_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("Failure: %s", why);
        stop_run();
    endtask

    function automatic string write_text(input wb_write_t w);
        return $sformatf("we=%0b waddr=%0d wdata=%h pc=%h", w.we, w.waddr, w.wdata, w.pc);
    endfunction

    task automatic compare_write(input string name, input wb_write_t exp, input wb_write_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %s actual %s", name,
                     write_text(exp), write_text(act));
            stop_run();
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Sequential model of one lane, updates the shadow registers
    function automatic wb_write_t ref_lane(input slot_t s);
        wb_write_t               w;
        logic [XLEN-1:0]         x;
        logic [XLEN-1:0]         y;
        logic [XLEN-1:0]         a;
        logic [XLEN-1:0]         b;
        logic signed [2*XLEN-1:0] ps;
        logic [2*XLEN-1:0]       pu;
        x  = shadow[s.raddr1];
        y  = shadow[s.raddr2];
        a  = (s.src1 == SRC_PC) ? s.pc : x;
        b  = (s.src2 == SRC_IMM) ? s.imm : y;
        ps = $signed({{XLEN{x[XLEN-1]}}, x}) * $signed({{XLEN{y[XLEN-1]}}, y});
        pu = {{XLEN{1'b0}}, x} * {{XLEN{1'b0}}, y};
        case (s.alu_op)
            ADD:     w.wdata = a + b;
            SUB:     w.wdata = a - b;
            AND:     w.wdata = a & b;
            OR:      w.wdata = a | b;
            XOR:     w.wdata = a ^ b;
            SLL:     w.wdata = a << b[4:0];
            SRL:     w.wdata = a >> b[4:0];
            SRA:     w.wdata = $signed(a) >>> b[4:0];
            SLT:     w.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    w.wdata = (a < b) ? 32'd1 : 32'd0;
            MUL:     w.wdata = pu[XLEN-1:0];
            MULH:    w.wdata = ps[2*XLEN-1:XLEN];
            MULHU:   w.wdata = pu[2*XLEN-1:XLEN];
            default: w.wdata = '0;
        endcase
        w.we    = s.rf_we;
        w.waddr = s.waddr;
        w.pc    = s.pc;
        if (s.rf_we && s.waddr != '0) begin
            shadow[s.waddr] = w.wdata;                              // Register zero stays zero
        end
        return w;
    endfunction

    function automatic wb_pair_t ref_pair(input issue_pair_t p);
        wb_pair_t e;
        e.a = ref_lane(p.a);                                        // Lane A first
        e.b = ref_lane(p.b);
        return e;
    endfunction

    function automatic slot_t rand_slot(input logic [4:0] mask, input logic mul_mode);
        slot_t       s;
        logic [31:0] r;
        r        = rand32();
        s.pc     = rand32() & 32'hffff_fffc;
        s.imm    = rand32();
        s.raddr1 = r[4:0] & mask;
        s.raddr2 = r[9:5] & mask;
        s.waddr  = r[14:10] & mask;
        s.rf_we  = (r[16:15] != 2'b00);
        s.src1   = r[17] ? SRC_PC : SRC_REG;
        s.src2   = r[18] ? SRC_IMM : SRC_REG;
        s.alu_op = alu_op_e'(r[23:20] % 4'd10);
        if (mul_mode) begin
            s.src1   = SRC_REG;                                     // Multiplier reads registers
            s.src2   = SRC_REG;
            s.alu_op = (r[25:24] == 2'd0) ? MUL : (r[25:24] == 2'd1) ? MULH : MULHU;
        end
        return s;
    endfunction

    function automatic issue_pair_t rand_pair(input logic [4:0] mask, input logic mul_mode);
        issue_pair_t p;
        logic [31:0] corner [8];
        corner = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                   32'h7fff_ffff, 32'h0000_ffff, 32'hffff_0000, 32'h1234_5678};
        p.a = rand_slot(mask, 1'b0);
        p.b = rand_slot(mask, mul_mode);
        if (mul_mode) begin
            p.a.alu_op = ADD;                                       // Load a corner value
            p.a.src1   = SRC_REG;
            p.a.raddr1 = '0;
            p.a.src2   = SRC_IMM;
            p.a.imm    = corner[p.a.imm[2:0]];
        end
        // Lane B never reads lane A's destination
        if (p.b.raddr1 == p.a.waddr) p.b.raddr1 = p.b.raddr1 ^ 5'd1;
        if (p.b.raddr2 == p.a.waddr) p.b.raddr2 = p.b.raddr2 ^ 5'd1;
        return p;
    endfunction

    task automatic step(input logic do_issue, input issue_pair_t p, output logic issued);
        @(negedge clk);
        issued    = do_issue && (issue_credits > 0);
        wb_credit = !hold && (pending > 0);
        if (wb_credit) pending--;
        issue_valid = issued;
        issue_pair  = p;
        if (issued) begin
            issue_credits--;
            accepted++;
            exp_q.push_back(ref_pair(p));
        end
    endtask

    task automatic send_pair(input issue_pair_t p);
        logic done;
        done = 1'b0;
        while (!done) step(1'b1, p, done);
    endtask

    task automatic idle();
        logic unused;
        step(1'b0, '0, unused);
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || pending != 0) idle();
        idle();
    endtask

    // Compare process
    always @(posedge clk) begin
        if (!reset) begin
            if (credit_return) begin
                returns++;
                issue_credits++;
                if (returns > accepted) abort_run("credit_return pulse with no pair outstanding");
            end
            if (wb_valid) begin
                if (exp_q.size() == 0) abort_run("wb_valid with no pair expected");
                if (out_credits == 0) abort_run("wb_valid raised without an output credit");
                compare_write({test_name, " lane A"}, exp_q[0].a, wb_pair.a);
                compare_write({test_name, " lane B"}, exp_q[0].b, wb_pair.b);
                void'(exp_q.pop_front());
                delivered++;
                pending++;
            end
            // Queue plus MEM and WB registers
            if (accepted - delivered > ISSUE_CREDITS + 2) begin
                abort_run("DUT holds more pairs than its queue and stages can store");
            end
            out_credits = out_credits + int'(wb_credit) - int'(wb_valid);
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        abort_run("watchdog timeout, the pipeline stopped delivering");
    end

    initial begin
        issue_pair_t p;
        logic        issued;
        int          d0;
        int          r_mid;
        int          r0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_pair  = '0;
        wb_credit   = 1'b0;
        hold        = 1'b0;
        lcg_state   = 32'd69042;
        for (int r = 0; r < NUM_REGS; r++) shadow[r] = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_name = "reset";
        repeat (3) begin
            idle();
            compare_count("reset wb_valid", 0, int'(wb_valid));
            compare_count("reset credit_return", 0, int'(credit_return));
        end
        p = '0;
        p.a.src2 = SRC_IMM;                                         // r0 = 0x1234, reported only
        p.a.imm = 32'h1234;
        p.a.rf_we = 1'b1;
        p.b.src2 = SRC_IMM;
        p.b.imm = 32'h5;
        p.b.rf_we = 1'b1;
        p.b.waddr = 5'd3;
        send_pair(p);
        p = '0;
        p.a.alu_op = OR;
        p.a.raddr2 = 5'd3;
        p.a.rf_we = 1'b1;
        p.a.waddr = 5'd4;
        p.b.rf_we = 1'b1;
        p.b.waddr = 5'd5;
        send_pair(p);

        test_name = "spaced";
        repeat (N_SPACED) begin
            send_pair(rand_pair(5'h1f, 1'b0));
            repeat (4) idle();
        end
        test_name = "dependent";
        repeat (N_DEP) send_pair(rand_pair(5'h07, 1'b0));
        test_name = "multiply";
        repeat (N_MUL) send_pair(rand_pair(5'h07, 1'b1));
        drain();

        test_name = "stall";
        hold = 1'b1;
        d0 = delivered;
        r_mid = 0;
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            step(1'b1, rand_pair(5'h07, 1'b0), issued);
            if (c == HOLD_CYCLES / 2) r_mid = returns;
        end
        compare_count("stall wb_valid count", WB_CREDITS, delivered - d0);
        compare_count("stall credit_return", r_mid, returns);
        hold = 1'b0;
        r0 = returns;
        while (returns == r0) idle();

        test_name = "after stall";
        repeat (N_AFTER) send_pair(rand_pair(5'h07, 1'b0));
        drain();
        compare_count("credit_return pulses", accepted, returns);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
